// ==== bench/decodeStageTb.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module decodeStageTb;

    localparam int clkPeriod   = 100;
    localparam int resetCycles = 8;
    localparam int nWarm       = 8;
    localparam int nDecode     = 400;
    localparam int nRegs       = 300;
    localparam int nHazard     = 40;
    localparam int nIllegal    = 200;
    localparam int totalCycles = resetCycles + nWarm + nDecode + nRegs + nHazard * 8
                                 + nIllegal + 10; // up to two drain cycles per test.
    localparam int gOp    = 0;
    localparam int gOpImm = 1;
    localparam int gLoad  = 2;
    localparam int gStore = 3;

    logic                   clk;
    logic                   rstN;
    logic                   instrValid;
    decodePkg::instrWord    instr;
    logic                   wbEn;
    logic [`REG_ADDR_W-1:0] wbAddr;
    logic [`XLEN-1:0]       wbData;
    logic                   stall;
    logic                   exValid;
    decodePkg::aluOp        exOp;
    decodePkg::loadSize     exMemSize;
    logic                   exRegWrite, exMemRead, exMemWrite, exUseImm, exIllegal;
    logic [`XLEN-1:0]       exRs1Val, exRs2Val, exImm;
    logic [`REG_ADDR_W-1:0] exRd;

    // instruction offered by fetch and what it decodes to.
    decodePkg::instrWord    curInstr;
    logic                   curValid;
    decodePkg::aluOp        eOp;
    decodePkg::loadSize     eSize;
    logic [`XLEN-1:0]       eImm;
    logic                   eUseImm, eUseRs1, eUseRs2, eRegWrite, eMemRead, eMemWrite, eIllegal;
    // expected contents of the ID/EX register.
    logic                   xValid, xRegWrite, xMemRead, xMemWrite, xUseImm, xIllegal;
    decodePkg::aluOp        xOp;
    decodePkg::loadSize     xSize;
    logic [`XLEN-1:0]       xRs1, xRs2, xImm;
    logic [`REG_ADDR_W-1:0] xRd;
    logic [`XLEN-1:0]       mirror [`REG_COUNT];

    logic [31:0] lfsr;
    logic        lastStall;
    logic        wbAllowed;
    string       testName;
    int          checks, errors, testChecks, testErrors, testCount, stallCount;

    decodeStage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    ////////////////////
    // model helpers
    ////////////////////

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int randRange(input int n);
        return int'(randBits(8)) % n;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return v[11] ? {20'hfffff, v} : {20'h00000, v};
    endfunction

    // funct3 meaning for the OP and OP-IMM groups.
    function automatic decodePkg::aluOp opFor(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? decodePkg::ALU_SUB : decodePkg::ALU_ADD;
            3'b001:  return decodePkg::ALU_SLL;
            3'b010:  return decodePkg::ALU_SLT;
            3'b100:  return decodePkg::ALU_XOR;
            3'b101:  return decodePkg::ALU_SRL;
            3'b110:  return decodePkg::ALU_OR;
            default: return decodePkg::ALU_AND;
        endcase
    endfunction

    function automatic decodePkg::loadSize sizeFor(input logic [2:0] f3);
        case (f3)
            3'b000:  return decodePkg::LD_B;
            3'b001:  return decodePkg::LD_H;
            3'b010:  return decodePkg::LD_W;
            3'b100:  return decodePkg::LD_BU;
            default: return decodePkg::LD_HU;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] readModel(input logic [`REG_ADDR_W-1:0] a);
        return (a == '0) ? '0 : (wbEn && wbAddr == a) ? wbData : mirror[a]; // bypass first.
    endfunction

    task automatic checkEq(input string what, input logic [31:0] expV, input logic [31:0] actV);
        checks++;
        testChecks++;
        valueMatches: assert (actV === expV) else begin
            $display("Mismatch %s %s: expected %h, actual %h", testName, what, expV, actV);
            errors++;
            testErrors++;
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checks++;
        testChecks++;
        condHolds: assert (cond) else begin
            $display("Error in %s: %s", testName, what);
            errors++;
            testErrors++;
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    task automatic buildLegal(input int group, input logic [4:0] rdA, input logic [4:0] rs1A,
                              input logic [4:0] rs2A);
        decodePkg::instrWord w;
        logic [2:0] f3;
        w = randBits(32);
        w.rType.rd  = rdA;
        w.rType.rs1 = rs1A;
        w.rType.rs2 = rs2A;
        f3 = 3'(randBits(3));
        eOp = decodePkg::ALU_ADD;
        eSize = decodePkg::LD_NONE;
        eUseImm = 1'b1;
        eUseRs1 = 1'b1;
        eUseRs2 = 1'b0;
        eRegWrite = 1'b1;
        eMemRead = 1'b0;
        eMemWrite = 1'b0;
        eIllegal = 1'b0;
        case (group)
            gOp: begin
                while (f3 == 3'b011)
                    f3 = 3'(randBits(3)); // no sltu.
                w.rType.opcode = `OPC_OP;
                w.rType.funct7 = (f3 == 3'b000 && randBits(1) == 1) ? 7'h20 : 7'h00;
                eOp = opFor(f3, w.rType.funct7[5]);
                eImm = '0;
                eUseImm = 1'b0;
                eUseRs2 = 1'b1;
            end
            gOpImm: begin
                while (f3 == 3'b011)
                    f3 = 3'(randBits(3));
                w.rType.opcode = `OPC_OPIMM;
                if (f3[1:0] == 2'b01) begin
                    w.rType.funct7 = 7'h00; // shift amount only.
                end
                eOp = opFor(f3, 1'b0);
                eImm = sext12(w.iType.imm12);
            end
            gLoad: begin
                while (f3 == 3'b011 || f3 > 3'b101)
                    f3 = 3'(randBits(3));
                w.rType.opcode = `OPC_LOAD;
                eSize = sizeFor(f3);
                eMemRead = 1'b1;
                eImm = sext12(w.iType.imm12);
            end
            gStore: begin
                while (f3 > 3'b010)
                    f3 = 3'(randBits(3));
                w.rType.opcode = `OPC_STORE;
                eSize = sizeFor(f3);
                eRegWrite = 1'b0;
                eMemWrite = 1'b1;
                eUseRs2 = 1'b1;
                eImm = sext12({w.sType.immHi, w.sType.immLo});
            end
            default: begin
                w.rType.opcode = `OPC_LUI;
                eOp = decodePkg::ALU_PASSB;
                eUseRs1 = 1'b0;
                eImm = {w.rType.funct7, w.rType.rs2, w.rType.rs1, f3, 12'h000};
            end
        endcase
        w.rType.funct3 = f3;
        curInstr = w;
    endtask

    task automatic buildIllegal();
        logic [31:0] bits;
        bits = randBits(32);
        while (bits[6:0] == `OPC_OP || bits[6:0] == `OPC_OPIMM || bits[6:0] == `OPC_LOAD
               || bits[6:0] == `OPC_STORE || bits[6:0] == `OPC_LUI)
            bits[6:0] = 7'(randBits(7));
        curInstr = bits;
        eUseRs1 = 1'b0;
        eUseRs2 = 1'b0;
        eRegWrite = 1'b0;
        eMemRead = 1'b0;
        eMemWrite = 1'b0;
        eIllegal = 1'b1;
    endtask

    task automatic pickAny(input int illegalOneIn);
        if (randRange(illegalOneIn) == 0) begin
            buildIllegal();
        end else begin
            buildLegal(randRange(5), 5'(randBits(3)), 5'(randBits(3)), 5'(randBits(3)));
        end
    endtask

    task automatic checkEx();
        checkEq("exValid", 32'(xValid), 32'(exValid));
        checkEq("exRegWrite", 32'(xRegWrite), 32'(exRegWrite));
        checkEq("exMemRead", 32'(xMemRead), 32'(exMemRead));
        checkEq("exMemWrite", 32'(xMemWrite), 32'(exMemWrite));
        checkEq("exIllegal", 32'(xIllegal), 32'(exIllegal));
        if (xValid && !xIllegal) begin
            checkEq("exOp", 32'(xOp), 32'(exOp));
            checkEq("exMemSize", 32'(xSize), 32'(exMemSize));
            checkEq("exUseImm", 32'(xUseImm), 32'(exUseImm));
            checkEq("exImm", xImm, exImm);
            checkEq("exRd", 32'(xRd), 32'(exRd));
            checkEq("exRs1Val", xRs1, exRs1Val);
            checkEq("exRs2Val", xRs2, exRs2Val);
        end
    endtask

    // each clock checks the last issue, drives, checks stall and predicts the next issue.
    task automatic doCycle();
        logic             expStall;
        logic [`XLEN-1:0] rs1Exp;
        logic [`XLEN-1:0] rs2Exp;
        @(posedge clk);
        #1;
        checkEx();
        instrValid = curValid;
        instr      = curInstr;
        wbEn       = wbAllowed && randBits(1) == 1;
        wbAddr     = 5'(randBits(3));
        wbData     = randBits(32);
        expStall = curValid && xValid && xMemRead && xRd != '0
                   && ((eUseRs1 && curInstr.rType.rs1 == xRd)
                       || (eUseRs2 && curInstr.rType.rs2 == xRd));
        #40;
        checkEq("stall", 32'(expStall), 32'(stall));
        rs1Exp = readModel(curInstr.rType.rs1);
        rs2Exp = readModel(curInstr.rType.rs2);
        if (wbEn && wbAddr != '0) begin
            mirror[wbAddr] = wbData;
        end
        if (curValid && !expStall) begin
            xValid = 1'b1;
            xRegWrite = eRegWrite;
            xMemRead = eMemRead;
            xMemWrite = eMemWrite;
            xIllegal = eIllegal;
            xOp = eOp;
            xSize = eSize;
            xUseImm = eUseImm;
            xRs1 = rs1Exp;
            xRs2 = rs2Exp;
            xImm = eImm;
            xRd = curInstr.rType.rd;
        end else begin
            xValid = 1'b0; // bubble, payload held.
            xRegWrite = 1'b0;
            xMemRead = 1'b0;
            xMemWrite = 1'b0;
            xIllegal = 1'b0;
        end
        lastStall = expStall;
        stallCount += int'(stall === 1'b1);
    endtask

    task automatic startTest(input string name);
        testName = name;
        testChecks = 0;
        testErrors = 0;
        stallCount = 0;
    endtask

    task automatic finishTest();
        while (lastStall)
            doCycle();
        curValid = 1'b0;
        doCycle();
        $display("%s: %0d checks, %0d errors", testName, testChecks, testErrors);
        testCount++;
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        logic [4:0] r;
        logic [4:0] other;
        lfsr = 32'h85cda09e;
        checks = 0;
        errors = 0;
        testCount = 0;
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        wbEn = 1'b0;
        wbAddr = '0;
        wbData = '0;
        curValid = 1'b0;
        lastStall = 1'b0;
        wbAllowed = 1'b0;
        xValid = 1'b0;
        xRegWrite = 1'b0;
        xMemRead = 1'b0;
        xMemWrite = 1'b0;
        xIllegal = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            mirror[i] = '0;
        end
        buildLegal(gOp, 5'd0, 5'd0, 5'd0);

        startTest("reset");
        repeat (resetCycles) begin
            @(posedge clk);
            #1;
            checkEx();
            checkEq("stall", 32'd0, 32'(stall));
        end
        rstN = 1'b1;
        curValid = 1'b1;
        repeat (nWarm) begin
            buildLegal(gOp, 5'(randBits(3)), 5'(randBits(3)), 5'(randBits(3))); // reads zeros.
            doCycle();
        end
        finishTest();

        startTest("decode");
        wbAllowed = 1'b1;
        repeat (nDecode) begin
            if (!lastStall) begin
                pickAny(16);
                curValid = randRange(4) != 0;
            end
            doCycle();
        end
        finishTest();

        startTest("regfile");
        repeat (nRegs) begin
            if (!lastStall) begin
                buildLegal(randBits(1) == 1 ? gOp : gStore, 5'(randBits(3)), 5'(randBits(3)),
                           5'(randBits(3)));
                curValid = randRange(4) != 0;
            end
            doCycle();
        end
        finishTest();

        startTest("load-use");
        for (int i = 0; i < nHazard; i++) begin
            r = 5'(randRange(7) + 1);
            other = 5'(int'(r) % 7 + 1);
            curValid = 1'b0;
            doCycle();
            curValid = 1'b1;
            buildLegal(gLoad, r, 5'(randBits(3)), 5'(randBits(3)));
            doCycle();
            if (i % 2 == 0) begin
                buildLegal(gOp, 5'(randBits(3)), r, 5'(randBits(3)));
            end else begin
                buildLegal(gStore, 5'(randBits(3)), other, r);
            end
            doCycle();
            checkTrue(stall, "a consumer right after a load was not stalled");
            doCycle();
            checkTrue(!stall, "the load-use stall lasted more than one cycle");
            buildLegal(gLoad, r, 5'(randBits(3)), 5'(randBits(3)));
            doCycle();
            buildLegal(gOpImm, 5'(randBits(3)), other, r); // r sits in the unused rs2 field.
            doCycle();
            buildLegal(gLoad, 5'd0, 5'd0, 5'(randBits(3)));
            doCycle();
            buildLegal(gOp, 5'(randBits(3)), 5'd0, 5'd0);
            doCycle();
        end
        checkEq("stall cycles", 32'(nHazard), 32'(stallCount));
        finishTest();

        startTest("illegal");
        repeat (nIllegal) begin
            if (!lastStall) begin
                pickAny(2);
                curValid = 1'b1;
            end
            doCycle();
        end
        finishTest();

        $display("summary: %0d tests, %0d checks, %0d errors", testCount, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(2 * totalCycles * clkPeriod);
        $display("Timeout: the run did not finish within %0d clock cycles", 2 * totalCycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== include/decode_macros.svh ====
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

//////////////////////
// datapath sizes
//////////////////////

`define XLEN        32 // integer register width.
`define REG_COUNT   32
`define REG_ADDR_W  5  // log2 of the register count.

//////////////////////
// major opcodes
//////////////////////

`define OPC_OP      7'b0110011
`define OPC_OPIMM   7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_LUI     7'b0110111

`endif

// ==== sim.f ====
+incdir+include
verilog/decodePkg.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/loadUseDetect.sv
verilog/issueRegister.sv
verilog/decodeStage.sv
bench/decodeStageTb.sv

// ==== verilog/decodePkg.sv ====
`include "decode_macros.svh"

package decodePkg;

    ////////////////////
    // instruction views
    ////////////////////

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } rFields;

    typedef struct packed {
        logic [11:0]            imm12; // sign bit is imm12[11].
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } iFields;

    typedef struct packed {
        logic [6:0]             immHi;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             immLo; // sits where rd would be.
        logic [6:0]             opcode;
    } sFields;

    // one fetched word, read through whichever format the opcode selects
    typedef union packed {
        rFields rType;
        iFields iType;
        sFields sType;
    } instrWord;

    ////////////////////
    // control encodings
    ////////////////////

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASSB // operand b straight through, for lui.
    } aluOp;

    // values follow funct3 of the load group so the decoder can cast it
    typedef enum logic [2:0] {
        LD_B    = 3'b000,
        LD_H    = 3'b001,
        LD_W    = 3'b010,
        LD_BU   = 3'b100,
        LD_HU   = 3'b101,
        LD_NONE = 3'b111
    } loadSize;

endpackage

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module decodeStage (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    instrValid,
    input  decodePkg::instrWord     instr,
    input  logic                    wbEn,
    input  logic [`REG_ADDR_W-1:0]  wbAddr,
    input  logic [`XLEN-1:0]        wbData,
    output logic                    stall,
    output logic                    exValid,
    output decodePkg::aluOp         exOp,
    output decodePkg::loadSize      exMemSize,
    output logic                    exRegWrite,
    output logic                    exMemRead,
    output logic                    exMemWrite,
    output logic                    exUseImm,
    output logic [`XLEN-1:0]        exRs1Val,
    output logic [`XLEN-1:0]        exRs2Val,
    output logic [`XLEN-1:0]        exImm,
    output logic [`REG_ADDR_W-1:0]  exRd,
    output logic                    exIllegal
);

    logic [`REG_ADDR_W-1:0] rs1Addr;
    logic [`REG_ADDR_W-1:0] rs2Addr;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm;
    decodePkg::aluOp        op;
    decodePkg::loadSize     memSize;
    logic                   useRs1;
    logic                   useRs2;
    logic                   useImm;
    logic                   regWrite;
    logic                   memRead;
    logic                   memWrite;
    logic                   illegal;
    logic [`XLEN-1:0]       rs1Val;
    logic [`XLEN-1:0]       rs2Val;

    instrDecode decoder (
        .instr, .rs1Addr, .rs2Addr, .rd, .imm, .op, .memSize,
        .useRs1, .useRs2, .useImm, .regWrite, .memRead, .memWrite, .illegal
    );

    regFile gprs (
        .clk, .rstN, .wbEn, .wbAddr, .wbData,
        .rs1Addr, .rs2Addr, .rs1Val, .rs2Val
    );

    // checks against the instruction this stage issued last cycle.
    loadUseDetect hazard (
        .instrValid, .useRs1, .useRs2, .rs1Addr, .rs2Addr,
        .exValid, .exMemRead, .exRd,
        .loadUseStall (stall)
    );

    issueRegister idEx (
        .clk, .rstN, .instrValid,
        .loadUseStall (stall),
        .rs1Val, .rs2Val, .rd, .imm, .op, .memSize,
        .useImm, .regWrite, .memRead, .memWrite, .illegal,
        .exValid, .exOp, .exMemSize, .exRegWrite, .exMemRead, .exMemWrite,
        .exUseImm, .exRs1Val, .exRs2Val, .exImm, .exRd, .exIllegal
    );

endmodule

// ==== verilog/instrDecode.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module instrDecode (
    input  decodePkg::instrWord     instr,
    output logic [`REG_ADDR_W-1:0]  rs1Addr,
    output logic [`REG_ADDR_W-1:0]  rs2Addr,
    output logic [`REG_ADDR_W-1:0]  rd,
    output logic [`XLEN-1:0]        imm,
    output decodePkg::aluOp         op,
    output decodePkg::loadSize      memSize,
    output logic                    useRs1,
    output logic                    useRs2,
    output logic                    useImm,
    output logic                    regWrite,
    output logic                    memRead,
    output logic                    memWrite,
    output logic                    illegal
);

    // register fields sit at the same bits in every format.
    assign rs1Addr = instr.rType.rs1;
    assign rs2Addr = instr.rType.rs2;
    assign rd      = instr.rType.rd;

    always_comb begin
        imm      = '0;
        op       = decodePkg::ALU_ADD; // address add for loads and stores.
        memSize  = decodePkg::LD_NONE;
        useRs1   = 1'b0;
        useRs2   = 1'b0;
        useImm   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        illegal  = 1'b0;

        case (instr.rType.opcode)
            `OPC_OP: begin
                useRs1   = 1'b1;
                useRs2   = 1'b1;
                regWrite = 1'b1;
                case ({instr.rType.funct7, instr.rType.funct3})
                    {7'h00, 3'b000}: op = decodePkg::ALU_ADD;
                    {7'h20, 3'b000}: op = decodePkg::ALU_SUB;
                    {7'h00, 3'b111}: op = decodePkg::ALU_AND;
                    {7'h00, 3'b110}: op = decodePkg::ALU_OR;
                    {7'h00, 3'b100}: op = decodePkg::ALU_XOR;
                    {7'h00, 3'b010}: op = decodePkg::ALU_SLT;
                    {7'h00, 3'b001}: op = decodePkg::ALU_SLL;
                    {7'h00, 3'b101}: op = decodePkg::ALU_SRL;
                    default:         illegal = 1'b1;
                endcase
            end
            `OPC_OPIMM: begin
                imm      = {{(`XLEN-12){instr.iType.imm12[11]}}, instr.iType.imm12};
                useRs1   = 1'b1;
                useImm   = 1'b1;
                regWrite = 1'b1;
                case (instr.iType.funct3)
                    3'b000:  op = decodePkg::ALU_ADD;
                    3'b111:  op = decodePkg::ALU_AND;
                    3'b110:  op = decodePkg::ALU_OR;
                    3'b100:  op = decodePkg::ALU_XOR;
                    3'b010:  op = decodePkg::ALU_SLT;
                    3'b001:  op = decodePkg::ALU_SLL;
                    3'b101:  op = decodePkg::ALU_SRL;
                    default: illegal = 1'b1;
                endcase
                // shift amounts use imm[4:0]; the upper bits must be zero.
                if (instr.iType.funct3[1:0] == 2'b01 && instr.rType.funct7 != 7'h00) begin
                    illegal = 1'b1;
                end
            end
            `OPC_LOAD: begin
                imm      = {{(`XLEN-12){instr.iType.imm12[11]}}, instr.iType.imm12};
                useRs1   = 1'b1;
                useImm   = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
                case (instr.iType.funct3)
                    3'b000, 3'b001, 3'b010, 3'b100, 3'b101:
                        memSize = decodePkg::loadSize'(instr.iType.funct3);
                    default: illegal = 1'b1;
                endcase
            end
            `OPC_STORE: begin
                imm = {{(`XLEN-12){instr.sType.immHi[6]}}, instr.sType.immHi,
                       instr.sType.immLo};
                useRs1   = 1'b1;
                useRs2   = 1'b1;
                useImm   = 1'b1;
                memWrite = 1'b1;
                case (instr.sType.funct3)
                    3'b000, 3'b001, 3'b010:
                        memSize = decodePkg::loadSize'(instr.sType.funct3); // access width.
                    default: illegal = 1'b1;
                endcase
            end
            `OPC_LUI: begin
                imm = {instr.iType.imm12, instr.iType.rs1, instr.iType.funct3,
                       {(`XLEN-20){1'b0}}};
                op       = decodePkg::ALU_PASSB;
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            default: illegal = 1'b1;
        endcase

        // an illegal word reads nothing and writes nothing.
        if (illegal) begin
            memSize  = decodePkg::LD_NONE;
            useRs1   = 1'b0;
            useRs2   = 1'b0;
            regWrite = 1'b0;
            memRead  = 1'b0;
            memWrite = 1'b0;
        end
    end

endmodule

// ==== verilog/issueRegister.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module issueRegister (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    instrValid,
    input  logic                    loadUseStall,
    input  logic [`XLEN-1:0]        rs1Val,
    input  logic [`XLEN-1:0]        rs2Val,
    input  logic [`REG_ADDR_W-1:0]  rd,
    input  logic [`XLEN-1:0]        imm,
    input  decodePkg::aluOp         op,
    input  decodePkg::loadSize      memSize,
    input  logic                    useImm,
    input  logic                    regWrite,
    input  logic                    memRead,
    input  logic                    memWrite,
    input  logic                    illegal,
    output logic                    exValid,
    output decodePkg::aluOp         exOp,
    output decodePkg::loadSize      exMemSize,
    output logic                    exRegWrite,
    output logic                    exMemRead,
    output logic                    exMemWrite,
    output logic                    exUseImm,
    output logic [`XLEN-1:0]        exRs1Val,
    output logic [`XLEN-1:0]        exRs2Val,
    output logic [`XLEN-1:0]        exImm,
    output logic [`REG_ADDR_W-1:0]  exRd,
    output logic                    exIllegal
);

    logic issue;

    assign issue = instrValid && !loadUseStall; // consumed this edge.

    ////////////////////
    // control bits
    ////////////////////

    // anything not issued becomes a bubble.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exValid    <= 1'b0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exIllegal  <= 1'b0;
        end else begin
            exValid    <= issue;
            exRegWrite <= issue && regWrite;
            exMemRead  <= issue && memRead;
            exMemWrite <= issue && memWrite;
            exIllegal  <= issue && illegal;
        end
    end

    ////////////////////
    // payload
    ////////////////////

    // held through bubbles, qualified by exValid downstream.
    always_ff @(posedge clk) begin
        if (issue) begin
            exOp      <= op;
            exMemSize <= memSize;
            exUseImm  <= useImm;
            exRs1Val  <= rs1Val;
            exRs2Val  <= rs2Val;
            exImm     <= imm;
            exRd      <= rd;
        end
    end

    loadIsNotStore: assert property (
        @(posedge clk) disable iff (!rstN)
        exMemRead |-> exRegWrite && !exMemWrite
    ) else $error("issueRegister: load issued without a register write or as a store");

endmodule

// ==== verilog/loadUseDetect.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module loadUseDetect (
    input  logic                    instrValid,
    input  logic                    useRs1,
    input  logic                    useRs2,
    input  logic [`REG_ADDR_W-1:0]  rs1Addr,
    input  logic [`REG_ADDR_W-1:0]  rs2Addr,
    input  logic                    exValid,
    input  logic                    exMemRead,
    input  logic [`REG_ADDR_W-1:0]  exRd,
    output logic                    loadUseStall
);

    logic loadPending;
    logic rs1Hit;
    logic rs2Hit;

    // a load in EX whose result cannot be forwarded in time.
    assign loadPending = exValid && exMemRead && exRd != '0;

    assign rs1Hit = useRs1 && rs1Addr == exRd; // only sources that are read.
    assign rs2Hit = useRs2 && rs2Addr == exRd;

    assign loadUseStall = instrValid && loadPending && (rs1Hit || rs2Hit);

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps
`include "decode_macros.svh"

module regFile (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    wbEn,
    input  logic [`REG_ADDR_W-1:0]  wbAddr,
    input  logic [`XLEN-1:0]        wbData,
    input  logic [`REG_ADDR_W-1:0]  rs1Addr,
    input  logic [`REG_ADDR_W-1:0]  rs2Addr,
    output logic [`XLEN-1:0]        rs1Val,
    output logic [`XLEN-1:0]        rs2Val
);

    // x0 has no storage.
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    ////////////////////
    // write port
    ////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbAddr != '0) begin
            regs[wbAddr] <= wbData;
        end
    end

    ////////////////////
    // read ports
    ////////////////////

    // same-cycle writeback wins over the stored copy.
    function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wbEn && addr == wbAddr) begin
            return wbData;
        end else begin
            return regs[addr];
        end
    endfunction

    always_comb begin
        rs1Val = readPort(rs1Addr);
        rs2Val = readPort(rs2Addr);
    end

    // a value written at one edge reads back from storage on the next cycle.
    writeReadsBack: assert property (
        @(posedge clk) disable iff (!rstN)
        (wbEn && wbAddr != '0) ##1 (rs1Addr == $past(wbAddr) && !(wbEn && wbAddr == rs1Addr))
        |-> rs1Val == $past(wbData)
    ) else $error("regFile: a written register did not read back its value");

endmodule
